// ==== design/raster_consts.svh ====
//**********************************************************
// rasterizer constants
//**********************************************************
`ifndef RASTER_CONSTS_SVH
`define RASTER_CONSTS_SVH

// visible area of the frame buffer, in pixels
`define RASTER_SCREEN_W 640
`define RASTER_SCREEN_H 480

// one coordinate field, wide enough for either axis
`define RASTER_COORD_W 10

// color index per pixel
`define RASTER_COLOR_W 3

`endif

// ==== design/raster_pixel_pkg.sv ====
//**********************************************************
// pixel data types
//**********************************************************
`include "raster_consts.svh"

package raster_pixel_pkg;

	// unsigned screen coordinate, covers 0..639 and 0..479
	typedef logic [`RASTER_COORD_W-1:0] coord_t;

	// color index of one pixel
	typedef logic [`RASTER_COLOR_W-1:0] color_t;

	// signed difference and Bresenham error term
	// one sign bit over a coordinate, plus one bit so that
	// the doubled error never overflows
	typedef logic signed [`RASTER_COORD_W+1:0] delta_t;

endpackage

// ==== design/raster_ctrl_pkg.sv ====
//**********************************************************
// sequencer control types
//**********************************************************
`include "raster_consts.svh"

package raster_ctrl_pkg;

	// frame sequence
	// idle waits for frame_start, clear scans the background,
	// wait_line offers line_ready, draw walks one segment
	typedef enum logic [1:0] {
		idle,
		clear,
		wait_line,
		draw
	} seq_state_t;

endpackage

// ==== design/screen_scanner.sv ====
//**********************************************************
// raster order screen scanner
//**********************************************************
`include "raster_consts.svh"

module screen_scanner (
	input  logic                     clk,
	input  logic                     rst,
	// control from the sequencer
	input  logic                     scan_start,
	input  logic                     scan_step,
	// current clear position
	output raster_pixel_pkg::coord_t scan_x,
	output raster_pixel_pkg::coord_t scan_y,
	output logic                     scan_last
);

	// right column and bottom row of the screen
	localparam raster_pixel_pkg::coord_t x_max =
		raster_pixel_pkg::coord_t'(`RASTER_SCREEN_W - 1);
	localparam raster_pixel_pkg::coord_t y_max =
		raster_pixel_pkg::coord_t'(`RASTER_SCREEN_H - 1);

	// end of a row
	logic row_end;

	assign row_end = (scan_x == x_max);

	// bottom right corner is the final clear pixel
	assign scan_last = row_end && (scan_y == y_max);

	// x runs fastest, y moves on each row wrap
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			scan_x <= '0;
			scan_y <= '0;
		end else if (scan_start) begin
			// new clear pass starts top left
			scan_x <= '0;
			scan_y <= '0;
		end else if (scan_step) begin
			if (scan_last) begin
				// whole screen done, back to origin
				scan_x <= '0;
				scan_y <= '0;
			end else if (row_end) begin
				scan_x <= '0;
				scan_y <= scan_y + 1'b1;
			end else begin
				scan_x <= scan_x + 1'b1;
			end
		end
	end

endmodule

// ==== design/line_stepper.sv ====
//**********************************************************
// Bresenham line stepper
//**********************************************************
`include "raster_consts.svh"

module line_stepper (
	input  logic                     clk,
	input  logic                     rst,
	// endpoints, captured on line_load
	input  logic                     line_load,
	input  raster_pixel_pkg::coord_t x0,
	input  raster_pixel_pkg::coord_t y0,
	input  raster_pixel_pkg::coord_t x1,
	input  raster_pixel_pkg::coord_t y1,
	// one step per accepted pixel
	input  logic                     step_adv,
	output raster_pixel_pkg::coord_t step_x,
	output raster_pixel_pkg::coord_t step_y,
	output logic                     step_last
);

	// endpoints widened to signed, so differences keep their sign
	raster_pixel_pkg::delta_t ext_x0, ext_y0, ext_x1, ext_y1;
	raster_pixel_pkg::delta_t diff_x, diff_y;
	raster_pixel_pkg::delta_t abs_dx, abs_dy;

	// walk state
	raster_pixel_pkg::coord_t end_x, end_y;
	raster_pixel_pkg::delta_t dx, neg_dy, err;
	logic                     x_dec, y_dec;

	// one step of the walk
	raster_pixel_pkg::delta_t err2, nxt_err;
	logic                     x_move, y_move;

	assign ext_x0 = {2'b00, x0};
	assign ext_y0 = {2'b00, y0};
	assign ext_x1 = {2'b00, x1};
	assign ext_y1 = {2'b00, y1};

	assign diff_x = ext_x1 - ext_x0;
	assign diff_y = ext_y1 - ext_y0;

	// absolute deltas, the sign goes to x_dec and y_dec
	assign abs_dx = diff_x[$bits(diff_x)-1] ? -diff_x : diff_x;
	assign abs_dy = diff_y[$bits(diff_y)-1] ? -diff_y : diff_y;

	// integer Bresenham, covers all eight octants
	// err2 is the doubled error, each test may add its delta
	always_comb begin
		err2    = err <<< 1;
		nxt_err = err;
		x_move  = 1'b0;
		y_move  = 1'b0;
		if (err2 >= neg_dy) begin
			nxt_err = nxt_err + neg_dy;
			x_move  = 1'b1;
		end
		if (err2 <= dx) begin
			nxt_err = nxt_err + dx;
			y_move  = 1'b1;
		end
	end

	// single endpoint compare for the whole design
	assign step_last = (step_x == end_x) && (step_y == end_y);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			step_x <= '0;
			step_y <= '0;
			end_x  <= '0;
			end_y  <= '0;
			dx     <= '0;
			neg_dy <= '0;
			err    <= '0;
			x_dec  <= 1'b0;
			y_dec  <= 1'b0;
		end else if (line_load) begin
			step_x <= x0;
			step_y <= y0;
			end_x  <= x1;
			end_y  <= y1;
			dx     <= abs_dx;
			// y delta is kept negative, as the walk compares against it
			neg_dy <= -abs_dy;
			err    <= abs_dx - abs_dy;
			x_dec  <= diff_x[$bits(diff_x)-1];
			y_dec  <= diff_y[$bits(diff_y)-1];
		end else if (step_adv) begin
			err <= nxt_err;
			if (x_move) begin
				step_x <= x_dec ? step_x - 1'b1 : step_x + 1'b1;
			end
			if (y_move) begin
				step_y <= y_dec ? step_y - 1'b1 : step_y + 1'b1;
			end
		end
	end

endmodule

// ==== design/raster_sequencer.sv ====
//**********************************************************
// frame sequencer
//**********************************************************
`include "raster_consts.svh"

module raster_sequencer (
	input  logic                     clk,
	input  logic                     rst,
	// frame control
	input  logic                     frame_start,
	input  raster_pixel_pkg::color_t bg_color,
	output logic                     frame_done,
	// line input handshake
	input  logic                     line_valid,
	input  raster_pixel_pkg::color_t line_color,
	input  logic                     line_last,
	output logic                     line_ready,
	// pixel output handshake
	input  logic                     pix_ready,
	output logic                     pix_valid,
	output raster_pixel_pkg::coord_t pix_x,
	output raster_pixel_pkg::coord_t pix_y,
	output raster_pixel_pkg::color_t pix_color,
	output logic                     pix_clear,
	// screen scanner
	input  raster_pixel_pkg::coord_t scan_x,
	input  raster_pixel_pkg::coord_t scan_y,
	input  logic                     scan_last,
	output logic                     scan_start,
	output logic                     scan_step,
	// line stepper
	input  raster_pixel_pkg::coord_t step_x,
	input  raster_pixel_pkg::coord_t step_y,
	input  logic                     step_last,
	output logic                     line_load,
	output logic                     step_adv
);

	raster_ctrl_pkg::seq_state_t state, nxt_state;

	// latched per frame and per line
	raster_pixel_pkg::color_t bg_q;
	raster_pixel_pkg::color_t color_q;
	logic                     last_q;

	logic in_clear, in_draw;
	// a pixel leaves on this edge
	logic pix_acc;
	// final pixel of the current line leaves on this edge
	logic line_done;

	assign in_clear  = (state == raster_ctrl_pkg::clear);
	assign in_draw   = (state == raster_ctrl_pkg::draw);
	assign pix_acc   = pix_valid && pix_ready;
	assign line_done = in_draw && pix_ready && step_last;

	// pixel port, valid for the whole clear and draw states
	assign pix_valid = in_clear || in_draw;
	assign pix_clear = in_clear;
	assign pix_x     = in_draw ? step_x : scan_x;
	assign pix_y     = in_draw ? step_y : scan_y;
	assign pix_color = in_clear ? bg_q : color_q;

	// only from state, never from line_valid
	assign line_ready = (state == raster_ctrl_pkg::wait_line);

	// scanner and stepper move only on an accepted pixel
	assign scan_start = (state == raster_ctrl_pkg::idle) && frame_start;
	assign scan_step  = in_clear && pix_acc;
	assign line_load  = line_ready && line_valid;
	assign step_adv   = in_draw && pix_acc && !step_last;

	always_comb begin
		nxt_state = state;
		case (state)
			raster_ctrl_pkg::idle: begin
				// frame_start elsewhere falls through unused
				if (frame_start) begin
					nxt_state = raster_ctrl_pkg::clear;
				end
			end
			raster_ctrl_pkg::clear: begin
				if (pix_ready && scan_last) begin
					nxt_state = raster_ctrl_pkg::wait_line;
				end
			end
			raster_ctrl_pkg::wait_line: begin
				if (line_valid) begin
					nxt_state = raster_ctrl_pkg::draw;
				end
			end
			raster_ctrl_pkg::draw: begin
				if (line_done) begin
					nxt_state = last_q ? raster_ctrl_pkg::idle : raster_ctrl_pkg::wait_line;
				end
			end
			default: begin
				nxt_state = raster_ctrl_pkg::idle;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state      <= raster_ctrl_pkg::idle;
			last_q     <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			state <= nxt_state;
			if (line_load) begin
				last_q <= line_last;
			end
			// high for the one cycle back in idle
			frame_done <= line_done && last_q;
		end
	end

	// colors for the pixel port
	always_ff @(posedge clk) begin
		if (scan_start) begin
			bg_q <= bg_color;
		end
		if (line_load) begin
			color_q <= line_color;
		end
	end

endmodule

// ==== design/line_rasterizer.sv ====
//**********************************************************
// line rasterizer top
//**********************************************************
`include "raster_consts.svh"

module line_rasterizer (
	input  logic                     clk,
	input  logic                     rst,
	// frame control
	input  logic                     frame_start,
	input  raster_pixel_pkg::color_t bg_color,
	output logic                     frame_done,
	// line input
	input  logic                     line_valid,
	output logic                     line_ready,
	input  raster_pixel_pkg::coord_t x0,
	input  raster_pixel_pkg::coord_t y0,
	input  raster_pixel_pkg::coord_t x1,
	input  raster_pixel_pkg::coord_t y1,
	input  raster_pixel_pkg::color_t line_color,
	input  logic                     line_last,
	// pixel output
	output logic                     pix_valid,
	input  logic                     pix_ready,
	output raster_pixel_pkg::coord_t pix_x,
	output raster_pixel_pkg::coord_t pix_y,
	output raster_pixel_pkg::color_t pix_color,
	output logic                     pix_clear
);

	// scanner side
	logic                     scan_start, scan_step, scan_last;
	raster_pixel_pkg::coord_t scan_x, scan_y;

	// stepper side
	logic                     line_load, step_adv, step_last;
	raster_pixel_pkg::coord_t step_x, step_y;

	screen_scanner i_screen_scanner (
		.clk        (clk),
		.rst        (rst),
		.scan_start (scan_start),
		.scan_step  (scan_step),
		.scan_x     (scan_x),
		.scan_y     (scan_y),
		.scan_last  (scan_last)
	);

	// endpoints go straight to the stepper, captured there on line_load
	line_stepper i_line_stepper (
		.clk       (clk),
		.rst       (rst),
		.line_load (line_load),
		.x0        (x0),
		.y0        (y0),
		.x1        (x1),
		.y1        (y1),
		.step_adv  (step_adv),
		.step_x    (step_x),
		.step_y    (step_y),
		.step_last (step_last)
	);

	raster_sequencer i_raster_sequencer (
		.clk         (clk),
		.rst         (rst),
		.frame_start (frame_start),
		.bg_color    (bg_color),
		.frame_done  (frame_done),
		.line_valid  (line_valid),
		.line_color  (line_color),
		.line_last   (line_last),
		.line_ready  (line_ready),
		.pix_ready   (pix_ready),
		.pix_valid   (pix_valid),
		.pix_x       (pix_x),
		.pix_y       (pix_y),
		.pix_color   (pix_color),
		.pix_clear   (pix_clear),
		.scan_x      (scan_x),
		.scan_y      (scan_y),
		.scan_last   (scan_last),
		.scan_start  (scan_start),
		.scan_step   (scan_step),
		.step_x      (step_x),
		.step_y      (step_y),
		.step_last   (step_last),
		.line_load   (line_load),
		.step_adv    (step_adv)
	);

endmodule

// ==== bench/clock_gen.sv ====
//**********************************************************
// testbench clock and reset
//**********************************************************

module clock_gen (
	output logic clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 1ps;

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// reset held low for 16 cycles, released away from the rising edge
	initial begin
		rst = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
	end

endmodule

// ==== bench/line_rasterizer_chk.sv ====
//**********************************************************
// rasterizer handshake assertions
//**********************************************************
`include "raster_consts.svh"

module line_rasterizer_chk (
	input logic                     clk,
	input logic                     rst,
	input logic                     pix_valid,
	input logic                     pix_ready,
	input raster_pixel_pkg::coord_t pix_x,
	input raster_pixel_pkg::coord_t pix_y,
	input raster_pixel_pkg::color_t pix_color,
	input logic                     pix_clear,
	input logic                     line_ready,
	input logic                     frame_done
);
	timeunit 1ns;
	timeprecision 1ps;

	// failed assertions so far, the testbench reads this at the end
	int unsigned fail_count = 0;

	// a stalled pixel stays on the port unchanged
	hold_a: assert property (@(posedge clk) disable iff (!rst)
		pix_valid && !pix_ready |=> pix_valid && $stable(pix_x) && $stable(pix_y)
			&& $stable(pix_color) && $stable(pix_clear))
	else begin
		fail_count++;
		$error("pixel port changed while pix_ready was low");
	end

	// end of frame is a single cycle pulse
	done_a: assert property (@(posedge clk) disable iff (!rst)
		frame_done |=> !frame_done)
	else begin
		fail_count++;
		$error("frame_done stayed high for more than one cycle");
	end

	// every emitted pixel lies on the screen
	range_a: assert property (@(posedge clk) disable iff (!rst)
		pix_valid |-> (pix_x < raster_pixel_pkg::coord_t'(`RASTER_SCREEN_W))
			&& (pix_y < raster_pixel_pkg::coord_t'(`RASTER_SCREEN_H)))
	else begin
		fail_count++;
		$error("pixel coordinate outside the screen");
	end

	// line input is only offered between pixel bursts
	excl_a: assert property (@(posedge clk) disable iff (!rst)
		!(line_ready && pix_valid))
	else begin
		fail_count++;
		$error("line_ready and pix_valid high together");
	end

endmodule

bind line_rasterizer line_rasterizer_chk i_line_rasterizer_chk (
	.clk        (clk),
	.rst        (rst),
	.pix_valid  (pix_valid),
	.pix_ready  (pix_ready),
	.pix_x      (pix_x),
	.pix_y      (pix_y),
	.pix_color  (pix_color),
	.pix_clear  (pix_clear),
	.line_ready (line_ready),
	.frame_done (frame_done)
);

// ==== bench/line_rasterizer_tb.sv ====
//**********************************************************
// line rasterizer testbench
//**********************************************************
`include "raster_consts.svh"

module line_rasterizer_tb #(
	parameter int seed = 61
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int n_lines = 12;
	localparam int clear_pixels = `RASTER_SCREEN_W * `RASTER_SCREEN_H;

	logic clk, rst;
	logic frame_start, frame_done;
	logic line_valid, line_ready, line_last;
	logic pix_valid, pix_ready, pix_clear;
	raster_pixel_pkg::color_t bg_color, line_color, pix_color;
	raster_pixel_pkg::coord_t x0, y0, x1, y1, pix_x, pix_y;

	// x0, y0, x1, y1, color, last
	// first frame walks the eight octants, second frame the special shapes
	int line_tab [n_lines][6] = '{
		'{100, 100, 140, 110, 1, 0},
		'{100, 100, 110, 140, 2, 0},
		'{200, 200, 190, 230, 3, 0},
		'{200, 200, 160, 212, 4, 0},
		'{300, 300, 260, 290, 5, 0},
		'{300, 300, 293, 260, 6, 0},
		'{ 50, 400,  60, 370, 7, 0},
		'{ 50, 400,  95, 385, 0, 1},
		'{  5,   5,   5,   5, 1, 0},
		'{  0, 479, 639, 479, 6, 0},
		'{639,   0, 639, 479, 3, 0},
		'{ 10,  10,  60,  60, 4, 1}
	};
	// background per frame
	int bg_tab [2] = '{2, 5};

	// predicted walk of the current line
	int exp_x [$];
	int exp_y [$];
	int cycles = 0;
	int limit = 0;
	int checks = 0;
	int errors = 0;
	int done_pulses = 0;

	clock_gen i_clock_gen (
		.clk (clk),
		.rst (rst)
	);

	line_rasterizer i_line_rasterizer (.*);

	// frame_done is registered, so the falling edge sees it settled
	always @(negedge clk) begin
		if (frame_done) begin
			done_pulses++;
		end
	end

	// watchdog, ends a run that stops making progress
	always @(negedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout after %0d cycles, the DUT stopped making progress", cycles);
			$display("Test failed");
			$finish;
		end
	end

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	// one cycle, inputs change on the falling edge
	task automatic next_cycle();
		@(negedge clk);
		// ready three times out of four
		pix_ready = ($urandom % 4) != 0;
	endtask

	// pixel count of a line, max(|dx|, |dy|) + 1
	function automatic int span(input int i);
		int dx;
		int dy;
		dx = line_tab[i][2] - line_tab[i][0];
		dy = line_tab[i][3] - line_tab[i][1];
		dx = (dx < 0) ? -dx : dx;
		dy = (dy < 0) ? -dy : dy;
		return ((dx > dy) ? dx : dy) + 1;
	endfunction

	// twice the pixels of all clear passes and lines, plus handshake slack
	function automatic int cycle_limit();
		int total;
		total = 0;
		for (int i = 0; i < n_lines; i++) begin
			total += span(i);
			if (line_tab[i][5] != 0) begin
				total += clear_pixels;
			end
		end
		return 2 * total + 20 * n_lines + 500;
	endfunction

	// integer Bresenham, both tests use the doubled error from before the step
	task automatic predict_line(input int i);
		int x;
		int y;
		int dx;
		int dy;
		int sx;
		int sy;
		int err;
		int e2;
		x = line_tab[i][0];
		y = line_tab[i][1];
		dx = line_tab[i][2] - x;
		dy = line_tab[i][3] - y;
		sx = (dx < 0) ? -1 : 1;
		sy = (dy < 0) ? -1 : 1;
		dx = (dx < 0) ? -dx : dx;
		dy = (dy < 0) ? -dy : dy;
		err = dx - dy;
		exp_x.delete();
		exp_y.delete();
		exp_x.push_back(x);
		exp_y.push_back(y);
		while (x != line_tab[i][2] || y != line_tab[i][3]) begin
			e2 = 2 * err;
			if (e2 >= -dy) begin
				err = err - dy;
				x = x + sx;
			end
			if (e2 <= dx) begin
				err = err + dx;
				y = y + sy;
			end
			exp_x.push_back(x);
			exp_y.push_back(y);
		end
	endtask

	task automatic start_frame(input int bg);
		next_cycle();
		frame_start = 1'b1;
		bg_color = raster_pixel_pkg::color_t'(bg);
		next_cycle();
		frame_start = 1'b0;
	endtask

	// whole screen in raster order, x fastest
	task automatic expect_clear(input int bg);
		int n;
		n = 0;
		while (n < clear_pixels) begin
			compare("line_ready", 32'(line_ready), 0);
			if (pix_valid && pix_ready) begin
				compare("pix_x", 32'(pix_x), n % `RASTER_SCREEN_W);
				compare("pix_y", 32'(pix_y), n / `RASTER_SCREEN_W);
				compare("pix_color", 32'(pix_color), bg);
				compare("pix_clear", 32'(pix_clear), 1);
				n++;
			end
			// stray frame_start in the middle of the pass
			frame_start = (n >= 1000 && n < 1010);
			next_cycle();
		end
		frame_start = 1'b0;
		compare("line_ready", 32'(line_ready), 1);
	endtask

	// data held until the edge that sees line_ready
	task automatic send_line(input int i);
		x0 = raster_pixel_pkg::coord_t'(line_tab[i][0]);
		y0 = raster_pixel_pkg::coord_t'(line_tab[i][1]);
		x1 = raster_pixel_pkg::coord_t'(line_tab[i][2]);
		y1 = raster_pixel_pkg::coord_t'(line_tab[i][3]);
		line_color = raster_pixel_pkg::color_t'(line_tab[i][4]);
		line_last = (line_tab[i][5] != 0);
		line_valid = 1'b1;
		while (!line_ready) begin
			next_cycle();
		end
		next_cycle();
		line_valid = 1'b0;
	endtask

	task automatic expect_line(input int i);
		int n;
		n = 0;
		predict_line(i);
		while (n < exp_x.size()) begin
			if (pix_valid && pix_ready) begin
				compare("pix_x", 32'(pix_x), exp_x[n]);
				compare("pix_y", 32'(pix_y), exp_y[n]);
				compare("pix_color", 32'(pix_color), line_tab[i][4]);
				compare("pix_clear", 32'(pix_clear), 0);
				n++;
			end
			next_cycle();
		end
		// no extra pixel, and the end of frame only after the last line
		compare("pix_valid", 32'(pix_valid), 0);
		compare("frame_done", 32'(frame_done), line_tab[i][5]);
	endtask

	initial begin
		int frame_no;
		int afails;
		logic new_frame;
		void'($urandom(seed));
		frame_start = 1'b0;
		bg_color = '0;
		line_valid = 1'b0;
		x0 = '0;
		y0 = '0;
		x1 = '0;
		y1 = '0;
		line_color = '0;
		line_last = 1'b0;
		pix_ready = 1'b0;
		limit = cycle_limit();
		wait (rst === 1'b1);
		// quiet while idle
		repeat (20) begin
			next_cycle();
			compare("pix_valid", 32'(pix_valid), 0);
			compare("line_ready", 32'(line_ready), 0);
			compare("frame_done", 32'(frame_done), 0);
		end
		frame_no = 0;
		new_frame = 1'b1;
		for (int i = 0; i < n_lines; i++) begin
			if (new_frame) begin
				start_frame(bg_tab[frame_no]);
				expect_clear(bg_tab[frame_no]);
				frame_no++;
			end
			send_line(i);
			expect_line(i);
			new_frame = (line_tab[i][5] != 0);
		end
		repeat (4) next_cycle();
		compare("frame_done pulses", done_pulses, frame_no);
		compare("pix_valid", 32'(pix_valid), 0);
		afails = i_line_rasterizer.i_line_rasterizer_chk.fail_count;
		$display("checks %0d, value errors %0d, assertion failures %0d", checks, errors, afails);
		if (errors == 0 && afails == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== line_rasterizer.f ====
+incdir+design
design/raster_pixel_pkg.sv
design/raster_ctrl_pkg.sv
design/screen_scanner.sv
design/line_stepper.sv
design/raster_sequencer.sv
design/line_rasterizer.sv
bench/clock_gen.sv
bench/line_rasterizer_chk.sv
bench/line_rasterizer_tb.sv

// ==== Makefile ====
# Verilator build and run of the line rasterizer testbench

VERILATOR ?= verilator
TOP       ?= line_rasterizer_tb
FILELIST  ?= line_rasterizer.f
OBJ_DIR   ?= obj_dir
SEED      ?= 61
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUNFLAGS  ?= +verilator+error+limit+1000

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Gseed=$(SEED) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-$(SIM) $(RUNFLAGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
